//--- build.f
+incdir+hdl
hdl/i2cPollPkg.sv
hdl/i2cCsr.sv
hdl/i2cBitTimer.sv
hdl/i2cByteShifter.sv
hdl/i2cSequencer.sv
hdl/i2cPollTop.sv
verification/i2cSlaveModel.sv
verification/i2cPollTb.sv

//--- hdl/i2cBitTimer.sv
// Quarter-bit tick generator for the I2C master
// Tick every divValue+1 clocks, phase counts the quarters of one SCL period
`default_nettype none
`include "i2cPoll_defs.svh"

module i2cBitTimer (
	input wire                        iSysClk,
	input wire                        rstN,
	input wire                        run,
	input wire [`I2C_DIV_WIDTH-1:0]   divValue,
	output logic                      tick,
	output logic [1:0]                phase
);

	logic [`I2C_DIV_WIDTH-1:0] cnt;

	// Down-counter, reload at zero
	// Phase seen with tick is the quarter that starts now
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt   <= '0;
			phase <= 2'd0;
		end
		else if (!run)
		begin
			// Parked so the first tick comes right after run rises
			cnt   <= '0;
			phase <= 2'd0;
		end
		else if (cnt == '0)
		begin
			cnt   <= divValue;
			phase <= phase + 2'd1;
		end
		else
		begin
			cnt <= cnt - 1'b1;
		end
	end

	assign tick = run && (cnt == '0);

	// Back-to-back ticks only with a zero divider
	assert property (@(posedge iSysClk) disable iff (!rstN)
		tick |=> !tick || ($past(divValue) == '0));

endmodule

`default_nettype wire

//--- hdl/i2cByteShifter.sv
// Byte shifter for SDA, MSB first, followed by the acknowledge bit
// Loaded by the sequencer, paced by the bit timer ticks
`default_nettype none

module i2cByteShifter (
	input wire         iSysClk,
	input wire         rstN,
	input wire         tick,
	input wire [1:0]   phase,
	input wire         shiftLoad,
	input wire         shiftDir,
	input wire [7:0]   shiftByte,
	input wire         ackOut,
	input wire         sdaIn,
	output logic       sdaDrive,
	output logic [7:0] rxByte,
	output logic       ackIn,
	output logic       byteDone,
	output logic       bitDone
);

	logic [7:0] shReg;
	logic       dirRx;
	logic       active;
	logic [3:0] bitCnt;
	logic       ackBit;

	// Bit 8 is the acknowledge slot
	assign ackBit = bitCnt == 4'd8;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			shReg    <= 8'd0;
			dirRx    <= 1'b0;
			active   <= 1'b0;
			bitCnt   <= 4'd0;
			sdaDrive <= 1'b0;
			ackIn    <= 1'b0;
		end
		else if (shiftLoad)
		begin
			shReg  <= shiftByte;
			dirRx  <= shiftDir;
			active <= 1'b1;
			bitCnt <= 4'd0;
			ackIn  <= 1'b0;
		end
		else if (tick)
		begin
			case (phase)
				// SDA moves only while SCL is low
				2'd0:
				begin
					if (!active)
						sdaDrive <= 1'b0;
					else if (!ackBit)
						sdaDrive <= !dirRx && !shReg[7];
					else
						sdaDrive <= dirRx && ackOut;
				end
				// Sample mid high period
				2'd2:
				begin
					if (active && !ackBit)
						shReg <= {shReg[6:0], sdaIn};
					else if (active && !dirRx)
						ackIn <= !sdaIn;
				end
				2'd3:
				begin
					if (active)
						bitCnt <= bitCnt + 4'd1;
					if (active && ackBit)
						active <= 1'b0;
				end
				default:
				begin
				end
			endcase
		end
	end

	// After eight samples the register holds the received byte
	assign rxByte   = shReg;
	// Strobes at the end of the last data bit and of the ack bit
	assign byteDone = active && tick && phase == 2'd3 && bitCnt == 4'd7;
	assign bitDone  = active && tick && phase == 2'd3 && ackBit;

endmodule

`default_nettype wire

//--- hdl/i2cCsr.sv
// APB register block of the polling I2C master
// Holds control, divider, slave addresses, sticky nack and the three results
`default_nettype none
`include "i2cPoll_defs.svh"

module i2cCsr (
	input wire                           iSysClk,
	input wire                           rstN,
	// APB slave side
	input wire                           pSel,
	input wire                           pEnable,
	input wire                           pWrite,
	input wire [`I2C_APB_ADDR_WIDTH-1:0] pAddr,
	input wire [31:0]                    pWData,
	output logic [31:0]                  pRData,
	output logic                         pReady,
	output logic                         pSlvErr,
	// Status and results from the sequencer
	input wire                           busy,
	input wire                           resultValid,
	input wire [1:0]                     resultIdx,
	input wire [15:0]                    resultData,
	input wire                           nackPulse,
	// Configuration out
	output logic                         enable,
	output logic [`I2C_DIV_WIDTH-1:0]    divValue,
	output i2cPollPkg::slaveAdrsU        slaveAdrs
);

	logic        nackReg;
	logic [15:0] resultReg [`I2C_SLAVE_COUNT];
	logic        access;
	logic        mapped;
	logic        wrEn;
	logic        nackClr;
	logic [7:0]  offset;
	logic [31:0] readData;

	// ----------------------------------------
	// Access decode
	// ----------------------------------------
	assign access = pSel && pEnable;
	assign offset = pAddr[7:0];
	assign pReady = 1'b1;

	always_comb
	begin
		mapped   = pAddr[11:8] == `I2C_BLOCK_ID;
		readData = '0;
		case (offset)
			`I2C_REG_CTRL:   readData = {31'd0, enable};
			`I2C_REG_DIV:    readData = {{(32 - `I2C_DIV_WIDTH){1'b0}}, divValue};
			`I2C_REG_SADRS:  readData = {8'd0, slaveAdrs.word};
			`I2C_REG_STATUS: readData = {30'd0, nackReg, busy};
			`I2C_REG_RES0:   readData = {16'd0, resultReg[0]};
			`I2C_REG_RES1:   readData = {16'd0, resultReg[1]};
			`I2C_REG_RES2:   readData = {16'd0, resultReg[2]};
			default:         mapped   = 1'b0;
		endcase
	end

	// Read data valid throughout the access cycle
	assign pRData  = readData;
	assign pSlvErr = access && !mapped;
	assign wrEn    = access && pWrite && mapped;
	// Write 1 to status bit 1 clears nack
	assign nackClr = wrEn && (offset == `I2C_REG_STATUS) && pWData[1];

	// ----------------------------------------
	// Registers
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enable    <= 1'b0;
			divValue  <= '0;
			slaveAdrs <= '0;
			nackReg   <= 1'b0;
			for (int i = 0; i < `I2C_SLAVE_COUNT; i++)
				resultReg[i] <= '0;
		end
		else
		begin
			if (wrEn && offset == `I2C_REG_CTRL)
				enable <= pWData[0];
			if (wrEn && offset == `I2C_REG_DIV)
				divValue <= pWData[`I2C_DIV_WIDTH-1:0];
			if (wrEn && offset == `I2C_REG_SADRS)
				slaveAdrs.word <= pWData[23:0];
			// Set beats clear in the same cycle
			if (nackPulse)
				nackReg <= 1'b1;
			else if (nackClr)
				nackReg <= 1'b0;
			if (resultValid && resultIdx < 2'(`I2C_SLAVE_COUNT))
				resultReg[resultIdx] <= resultData;
		end
	end

	// APB access phase always preceded by a selected cycle
	assert property (@(posedge iSysClk) disable iff (!rstN) pEnable |-> $past(pSel));

endmodule

`default_nettype wire

//--- hdl/i2cPollPkg.sv
// Shared types of the polling I2C master
// Referenced by scoped name from the CSR and the sequencer
`default_nettype none

package i2cPollPkg;

	// Three 7-bit slave addresses, one per byte
	// Left controller sits in the low byte
	typedef struct packed {
		logic [7:0] sensor;
		logic [7:0] right;
		logic [7:0] left;
	} slaveAdrsS;

	// Same 24 bits seen as the APB word or as per-slave bytes
	typedef union packed {
		logic [23:0] word;
		slaveAdrsS   slv;
	} slaveAdrsU;

	// Sequencer states, one transaction per pass from start to gap
	typedef enum logic [2:0] {
		seqIdle,
		seqStart,
		seqAddrByte,
		seqAddrAck,
		seqDataByte,
		seqMasterAck,
		seqStop,
		seqGap
	} seqStateE;

endpackage

`default_nettype wire

//--- hdl/i2cPollTop.sv
// Top of the polling I2C master with its APB register block
// Open-drain pins as pull-low enables plus sampled inputs
`default_nettype none
`include "i2cPoll_defs.svh"

module i2cPollTop (
	input wire                           iSysClk,
	input wire                           rstN,
	// APB
	input wire                           pSel,
	input wire                           pEnable,
	input wire                           pWrite,
	input wire [`I2C_APB_ADDR_WIDTH-1:0] pAddr,
	input wire [31:0]                    pWData,
	output logic [31:0]                  pRData,
	output logic                         pReady,
	output logic                         pSlvErr,
	// I2C pins
	output logic                         sclLow,
	output logic                         sdaLow,
	input wire                           sclIn,
	input wire                           sdaIn
);

	logic                      enable;
	logic [`I2C_DIV_WIDTH-1:0] divValue;
	i2cPollPkg::slaveAdrsU     slaveAdrs;
	logic                      busy;
	logic                      resultValid;
	logic [1:0]                resultIdx;
	logic [15:0]               resultData;
	logic                      nackPulse;
	logic                      timerRun;
	logic                      tick;
	logic [1:0]                phase;
	logic                      shiftLoad;
	logic                      shiftDir;
	logic [7:0]                shiftByte;
	logic                      ackOut;
	logic                      sdaDrive;
	logic [7:0]                rxByte;
	logic                      ackIn;
	logic                      byteDone;
	logic                      bitDone;
	// SCL input unused without clock stretching, observed only
	logic                      sclSeen;

	assign sclSeen = sclIn;

	i2cCsr csr0 (
		.iSysClk, .rstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData,
		.pRData, .pReady, .pSlvErr, .busy, .resultValid, .resultIdx,
		.resultData, .nackPulse, .enable, .divValue, .slaveAdrs
	);

	i2cBitTimer timer0 (
		.iSysClk, .rstN, .run(timerRun), .divValue, .tick, .phase
	);

	i2cByteShifter shifter0 (
		.iSysClk, .rstN, .tick, .phase, .shiftLoad, .shiftDir, .shiftByte,
		.ackOut, .sdaIn, .sdaDrive, .rxByte, .ackIn, .byteDone, .bitDone
	);

	i2cSequencer seq0 (
		.iSysClk, .rstN, .enable, .slaveAdrs, .tick, .phase, .rxByte, .ackIn,
		.byteDone, .bitDone, .sdaDrive, .timerRun, .shiftLoad, .shiftDir,
		.shiftByte, .ackOut, .sclLow, .sdaLow, .busy, .resultValid,
		.resultIdx, .resultData, .nackPulse
	);

	// Master never drives SCL low while it is released
	assert property (@(posedge iSysClk) disable iff (!rstN)
		(!sclLow && !$past(sclLow)) |-> (sclSeen || !busy || $isunknown(sclSeen)));

endmodule

`default_nettype wire

//--- hdl/i2cPoll_defs.svh
// Widths, APB register map and block id shared by the polling I2C master
// Included by the RTL files that need them
`ifndef I2C_POLL_DEFS_SVH
`define I2C_POLL_DEFS_SVH

// Divider and bus widths
`define I2C_DIV_WIDTH      16
`define I2C_APB_ADDR_WIDTH 12

// Address bits 11:8 select this block
`define I2C_BLOCK_ID       4'h1

// Register offsets within the block
`define I2C_REG_CTRL       8'h00
`define I2C_REG_DIV        8'h04
`define I2C_REG_SADRS      8'h08
`define I2C_REG_STATUS     8'h0C
`define I2C_REG_RES0       8'h80
`define I2C_REG_RES1       8'h84
`define I2C_REG_RES2       8'h88

// Slaves visited per polling round
`define I2C_SLAVE_COUNT    3

`endif

//--- hdl/i2cSequencer.sv
// Transaction FSM of the polling I2C master
// Start, address with read bit, two data bytes, stop and gap for each slave in turn
`default_nettype none
`include "i2cPoll_defs.svh"

module i2cSequencer (
	input wire                       iSysClk,
	input wire                       rstN,
	input wire                       enable,
	input wire i2cPollPkg::slaveAdrsU slaveAdrs,
	input wire                       tick,
	input wire [1:0]                 phase,
	input wire [7:0]                 rxByte,
	input wire                       ackIn,
	input wire                       byteDone,
	input wire                       bitDone,
	input wire                       sdaDrive,
	output logic                     timerRun,
	output logic                     shiftLoad,
	output logic                     shiftDir,
	output logic [7:0]               shiftByte,
	output logic                     ackOut,
	output logic                     sclLow,
	output logic                     sdaLow,
	output logic                     busy,
	output logic                     resultValid,
	output logic [1:0]               resultIdx,
	output logic [15:0]              resultData,
	output logic                     nackPulse
);

	i2cPollPkg::seqStateE state;
	logic       byteSel;
	logic       nackSeen;
	logic       holdLow;
	logic [1:0] idx;
	logic [7:0] curAdrs;
	logic       endBit;

	assign endBit = tick && phase == 2'd3;

	// Pick the address byte of the current slave
	always_comb
	begin
		case (idx)
			2'd1:    curAdrs = slaveAdrs.slv.right;
			2'd2:    curAdrs = slaveAdrs.slv.sensor;
			default: curAdrs = slaveAdrs.slv.left;
		endcase
	end

	// ----------------------------------------
	// Shifter control
	// ----------------------------------------
	// Load lands on the edge that ends the previous bit
	assign shiftLoad = (state == i2cPollPkg::seqStart && endBit)
		|| (state == i2cPollPkg::seqAddrAck && bitDone && ackIn)
		|| (state == i2cPollPkg::seqMasterAck && bitDone && !byteSel);
	assign shiftDir  = state != i2cPollPkg::seqStart;
	assign shiftByte = {curAdrs[6:0], 1'b1};
	// ACK after the high byte, NACK after the low byte
	assign ackOut    = state == i2cPollPkg::seqMasterAck && !byteSel;

	assign busy      = state != i2cPollPkg::seqIdle;
	assign timerRun  = state != i2cPollPkg::seqIdle;
	// Start and stop levels merged with the shifter drive
	assign sdaLow    = sdaDrive || holdLow;

	// ----------------------------------------
	// State machine
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state       <= i2cPollPkg::seqIdle;
			byteSel     <= 1'b0;
			nackSeen    <= 1'b0;
			holdLow     <= 1'b0;
			idx         <= 2'd0;
			sclLow      <= 1'b0;
			resultValid <= 1'b0;
			resultIdx   <= 2'd0;
			resultData  <= 16'd0;
			nackPulse   <= 1'b0;
		end
		else
		begin
			resultValid <= 1'b0;
			nackPulse   <= 1'b0;
			// SCL released on phases 1 and 2
			if (tick && phase == 2'd1)
				sclLow <= 1'b0;
			if (endBit && state inside {i2cPollPkg::seqStart, i2cPollPkg::seqAddrByte,
				i2cPollPkg::seqAddrAck, i2cPollPkg::seqDataByte, i2cPollPkg::seqMasterAck})
				sclLow <= 1'b1;
			// Hold released once the first address bit takes over
			if (tick && phase == 2'd0 && state != i2cPollPkg::seqStop)
				holdLow <= 1'b0;
			case (state)
				i2cPollPkg::seqIdle:
				begin
					nackSeen <= 1'b0;
					if (enable)
						state <= i2cPollPkg::seqStart;
				end
				i2cPollPkg::seqStart:
				begin
					// SDA falls with SCL high
					if (tick && phase == 2'd2)
						holdLow <= 1'b1;
					if (endBit)
						state <= i2cPollPkg::seqAddrByte;
				end
				i2cPollPkg::seqAddrByte:
				begin
					if (byteDone)
						state <= i2cPollPkg::seqAddrAck;
				end
				i2cPollPkg::seqAddrAck:
				begin
					if (bitDone && ackIn)
					begin
						byteSel <= 1'b0;
						state   <= i2cPollPkg::seqDataByte;
					end
					else if (bitDone)
					begin
						// No slave answered
						nackPulse <= 1'b1;
						nackSeen  <= 1'b1;
						state     <= i2cPollPkg::seqStop;
					end
				end
				i2cPollPkg::seqDataByte:
				begin
					if (byteDone)
						state <= i2cPollPkg::seqMasterAck;
				end
				i2cPollPkg::seqMasterAck:
				begin
					if (bitDone && !byteSel)
					begin
						resultData[15:8] <= rxByte;
						byteSel          <= 1'b1;
						state            <= i2cPollPkg::seqDataByte;
					end
					else if (bitDone)
					begin
						resultData[7:0] <= rxByte;
						state           <= i2cPollPkg::seqStop;
					end
				end
				i2cPollPkg::seqStop:
				begin
					// Low while SCL low, then rise with SCL high
					if (tick && phase == 2'd0)
						holdLow <= 1'b1;
					if (tick && phase == 2'd2)
						holdLow <= 1'b0;
					if (endBit)
						state <= i2cPollPkg::seqGap;
				end
				i2cPollPkg::seqGap:
				begin
					if (endBit)
					begin
						resultValid <= !nackSeen;
						// Slot of the finished slave goes out with the strobe
						resultIdx   <= idx;
						nackSeen    <= 1'b0;
						idx         <= (idx == 2'(`I2C_SLAVE_COUNT - 1)) ? 2'd0 : idx + 2'd1;
						state       <= enable ? i2cPollPkg::seqStart : i2cPollPkg::seqIdle;
					end
				end
				default:
					state <= i2cPollPkg::seqIdle;
			endcase
		end
	end

	// Data line moves under a high clock only for start and stop
	assert property (@(posedge iSysClk) disable iff (!rstN)
		(!sclLow && !$past(sclLow) && sdaLow != $past(sdaLow))
		|-> (state == i2cPollPkg::seqStart || state == i2cPollPkg::seqStop));

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Compile the polling I2C master and its testbench with Verilator, then run it.
# The exit status is 0 only when the testbench prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module i2cPollTb -Mdir obj_dir -f build.f \
	&& ./obj_dir/Vi2cPollTb 2>&1 | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

//--- verification/i2cPollTb.sv
// Testbench of the polling I2C master with three slave models on wired-AND lines
// Register table over APB first, then polling, nack and disable scenarios
`default_nettype none

module i2cPollTb;
	timeunit 1ns;
	timeprecision 1ps;

	// One APB operation of the register table
	typedef struct packed {
		logic        isWr;
		logic        chkData;
		logic [11:0] addr;
		logic [31:0] wData;
		logic [31:0] expData;
		logic        expErr;
	} apbOpS;

	localparam int numOps = 28;
	localparam int maxPolls = 1500;
	localparam logic [11:0] adrCtrl = 12'h100;
	localparam logic [11:0] adrDiv = 12'h104;
	localparam logic [11:0] adrSadrs = 12'h108;
	localparam logic [11:0] adrStatus = 12'h10C;
	localparam logic [11:0] adrRes0 = 12'h180;
	localparam logic [11:0] adrRes1 = 12'h184;
	localparam logic [11:0] adrRes2 = 12'h188;

	logic        iSysClk;
	logic        rstN;
	logic        pSel;
	logic        pEnable;
	logic        pWrite;
	logic [11:0] pAddr;
	logic [31:0] pWData;
	logic [31:0] pRData;
	logic        pReady;
	logic        pSlvErr;
	logic        sclLow;
	logic        sdaLow;
	wire         sclLine;
	wire         sdaLine;
	wire [2:0]   slvSdaLow;
	logic [6:0]  slvAdrs [3];
	logic [15:0] slvData [3];
	logic [15:0] oldData;
	logic [15:0] newData;
	logic [31:0] lcgState;
	logic [31:0] rData;
	logic        err;
	apbOpS       opTable [numOps];

	// Open-drain lines, released means high
	assign sclLine = !sclLow;
	assign sdaLine = !(sdaLow || (|slvSdaLow));

	i2cPollTop dut0 (
		.iSysClk, .rstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData,
		.pRData, .pReady, .pSlvErr, .sclLow, .sdaLow,
		.sclIn(sclLine), .sdaIn(sdaLine)
	);

	i2cSlaveModel slave0 (.scl(sclLine), .sda(sdaLine), .adrs(slvAdrs[0]),
		.data(slvData[0]), .sdaLow(slvSdaLow[0]));
	i2cSlaveModel slave1 (.scl(sclLine), .sda(sdaLine), .adrs(slvAdrs[1]),
		.data(slvData[1]), .sdaLow(slvSdaLow[1]));
	i2cSlaveModel slave2 (.scl(sclLine), .sda(sdaLine), .adrs(slvAdrs[2]),
		.data(slvData[2]), .sdaLow(slvSdaLow[2]));

	always #10 iSysClk = !iSysClk;

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
	endtask

	// Setup cycle, then access cycle sampled mid cycle
	task automatic apbAccess(input logic wr, input logic [11:0] addr,
		input logic [31:0] wData, output logic [31:0] rdOut, output logic errOut);
		@(negedge iSysClk);
		pSel    = 1'b1;
		pEnable = 1'b0;
		pWrite  = wr;
		pAddr   = addr;
		pWData  = wData;
		@(negedge iSysClk);
		pEnable = 1'b1;
		#5;
		checkValue("pReady", {31'd0, pReady}, 32'd1);
		rdOut  = pRData;
		errOut = pSlvErr;
		@(negedge iSysClk);
		pSel    = 1'b0;
		pEnable = 1'b0;
		pWrite  = 1'b0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        e;
		apbAccess(1'b1, addr, data, unused, e);
		checkValue("pSlvErr", {31'd0, e}, 32'd0);
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
		logic e;
		apbAccess(1'b0, addr, 32'd0, data, e);
		checkValue("pSlvErr", {31'd0, e}, 32'd0);
	endtask

	// Reads a register until the masked value matches, bounded
	task automatic pollReg(input string what, input logic [11:0] addr,
		input logic [31:0] mask, input logic [31:0] expected);
		logic [31:0] value;
		int          n;
		n = 0;
		apbRead(addr, value);
		while ((value & mask) !== expected && n < maxPolls)
		begin
			apbRead(addr, value);
			n++;
		end
		if ((value & mask) !== expected)
			failRun($sformatf("Timeout while waiting for %s", what));
	endtask

	// Fields: write, check data, address, write data, read data, slave error
	task automatic loadTable();
		opTable[0]  = '{1'b0, 1'b1, adrCtrl, 32'h0, 32'h0, 1'b0};
		opTable[1]  = '{1'b0, 1'b1, adrDiv, 32'h0, 32'h0, 1'b0};
		opTable[2]  = '{1'b0, 1'b1, adrSadrs, 32'h0, 32'h0, 1'b0};
		opTable[3]  = '{1'b0, 1'b1, adrStatus, 32'h0, 32'h0, 1'b0};
		opTable[4]  = '{1'b0, 1'b1, adrRes0, 32'h0, 32'h0, 1'b0};
		opTable[5]  = '{1'b0, 1'b1, adrRes1, 32'h0, 32'h0, 1'b0};
		opTable[6]  = '{1'b0, 1'b1, adrRes2, 32'h0, 32'h0, 1'b0};
		// Read-back masked to register widths
		opTable[7]  = '{1'b1, 1'b0, adrCtrl, 32'hFFFFFFFE, 32'h0, 1'b0};
		opTable[8]  = '{1'b0, 1'b1, adrCtrl, 32'h0, 32'h0, 1'b0};
		opTable[9]  = '{1'b1, 1'b0, adrDiv, 32'hABCD1234, 32'h0, 1'b0};
		opTable[10] = '{1'b0, 1'b1, adrDiv, 32'h0, 32'h1234, 1'b0};
		opTable[11] = '{1'b1, 1'b0, adrSadrs, 32'hFF5A3C96, 32'h0, 1'b0};
		opTable[12] = '{1'b0, 1'b1, adrSadrs, 32'h0, 32'h5A3C96, 1'b0};
		// Busy and results are read only
		opTable[13] = '{1'b1, 1'b0, adrStatus, 32'hFFFFFFFD, 32'h0, 1'b0};
		opTable[14] = '{1'b0, 1'b1, adrStatus, 32'h0, 32'h0, 1'b0};
		opTable[15] = '{1'b1, 1'b0, adrRes0, 32'h0000FFFF, 32'h0, 1'b0};
		opTable[16] = '{1'b0, 1'b1, adrRes0, 32'h0, 32'h0, 1'b0};
		opTable[17] = '{1'b1, 1'b0, adrRes1, 32'h00001234, 32'h0, 1'b0};
		opTable[18] = '{1'b0, 1'b1, adrRes1, 32'h0, 32'h0, 1'b0};
		opTable[19] = '{1'b1, 1'b0, adrRes2, 32'h0000BEEF, 32'h0, 1'b0};
		opTable[20] = '{1'b0, 1'b1, adrRes2, 32'h0, 32'h0, 1'b0};
		// Wrong block id or unlisted offset
		opTable[21] = '{1'b0, 1'b0, 12'h200, 32'h0, 32'h0, 1'b1};
		opTable[22] = '{1'b0, 1'b0, 12'h110, 32'h0, 32'h0, 1'b1};
		opTable[23] = '{1'b1, 1'b0, 12'h208, 32'h00123456, 32'h0, 1'b1};
		opTable[24] = '{1'b0, 1'b1, adrSadrs, 32'h0, 32'h5A3C96, 1'b0};
		opTable[25] = '{1'b1, 1'b0, 12'h004, 32'h00000777, 32'h0, 1'b1};
		opTable[26] = '{1'b0, 1'b1, adrDiv, 32'h0, 32'h1234, 1'b0};
		opTable[27] = '{1'b1, 1'b0, 12'h18C, 32'h00005555, 32'h0, 1'b1};
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		iSysClk    = 1'b0;
		rstN       = 1'b0;
		pSel       = 1'b0;
		pEnable    = 1'b0;
		pWrite     = 1'b0;
		pAddr      = 12'd0;
		pWData     = 32'd0;
		slvAdrs[0] = 7'h21;
		slvAdrs[1] = 7'h35;
		slvAdrs[2] = 7'h4A;
		// Slave data words from the LCG
		lcgState = 32'd50;
		for (int i = 0; i < 3; i++)
		begin
			lcgState   = lcgNext(lcgState);
			slvData[i] = lcgState[31:16];
		end
		lcgState = lcgNext(lcgState);
		newData  = lcgState[31:16];
		loadTable();
		repeat (3) @(posedge iSysClk);
		@(negedge iSysClk);
		rstN = 1'b1;

		// Lines released out of reset
		checkValue("sclLine", {31'd0, sclLine}, 32'd1);
		checkValue("sdaLine", {31'd0, sdaLine}, 32'd1);

		for (int i = 0; i < numOps; i++)
		begin
			apbAccess(opTable[i].isWr, opTable[i].addr, opTable[i].wData, rData, err);
			checkValue($sformatf("pSlvErr of op %0d", i), {31'd0, err},
				{31'd0, opTable[i].expErr});
			if (opTable[i].chkData)
				checkValue($sformatf("pRData of op %0d", i), rData, opTable[i].expData);
		end

		// Polling all three slaves
		apbWrite(adrDiv, 32'd3);
		apbWrite(adrSadrs, 32'h004A3521);
		apbWrite(adrCtrl, 32'd1);
		apbRead(adrCtrl, rData);
		checkValue("ctrl.enable", rData, 32'd1);
		pollReg("result 0", adrRes0, 32'hFFFFFFFF, {16'd0, slvData[0]});
		pollReg("result 1", adrRes1, 32'hFFFFFFFF, {16'd0, slvData[1]});
		pollReg("result 2", adrRes2, 32'hFFFFFFFF, {16'd0, slvData[2]});
		apbRead(adrStatus, rData);
		checkValue("status.nack", {31'd0, rData[1]}, 32'd0);
		checkValue("status.busy", {31'd0, rData[0]}, 32'd1);

		// Right slave address now matches no model
		apbWrite(adrSadrs, 32'h004A3621);
		pollReg("nack after the address change", adrStatus, 32'h2, 32'h2);
		// Model no longer addressed, a fresh word must never show up
		oldData    = slvData[1];
		slvData[1] = newData;
		apbWrite(adrStatus, 32'h2);
		apbRead(adrStatus, rData);
		checkValue("status.nack", {31'd0, rData[1]}, 32'd0);
		pollReg("nack on the next poll", adrStatus, 32'h2, 32'h2);
		apbRead(adrRes1, rData);
		checkValue("res1", rData, {16'd0, oldData});
		apbRead(adrRes0, rData);
		checkValue("res0", rData, {16'd0, slvData[0]});
		apbRead(adrRes2, rData);
		checkValue("res2", rData, {16'd0, slvData[2]});

		// Disable, current transaction ends then idle
		apbWrite(adrCtrl, 32'd0);
		pollReg("busy to drop", adrStatus, 32'h1, 32'h0);
		for (int k = 0; k < 200; k++)
		begin
			@(negedge iSysClk);
			checkValue("sclLine", {31'd0, sclLine}, 32'd1);
			checkValue("sdaLine", {31'd0, sdaLine}, 32'd1);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/i2cSlaveModel.sv
// Behavioural read-only I2C slave for the testbench
// Answers a read of its 7-bit address with the two bytes of data, high byte first
`default_nettype none

module i2cSlaveModel (
	input wire        scl,
	input wire        sda,
	input wire [6:0]  adrs,
	input wire [15:0] data,
	output logic      sdaLow
);
	timeunit 1ns;
	timeprecision 1ps;

	logic       sclLast;
	logic       sdaLast;
	logic       listening;
	logic [1:0] frame;
	logic [3:0] bitCnt;
	logic [7:0] shIn;

	// Bit k of the byte sent in frame f, MSB first
	function automatic logic txBit(input logic [1:0] f, input logic [3:0] k);
		logic [7:0] b;
		b = (f == 2'd1) ? data[15:8] : data[7:0];
		return b[3'(7 - k)];
	endfunction

	initial
	begin
		sdaLow    = 1'b0;
		listening = 1'b0;
		frame     = 2'd0;
		bitCnt    = 4'd0;
		shIn      = 8'd0;
		sclLast   = 1'b1;
		sdaLast   = 1'b1;
		forever
		begin
			@(scl or sda);
			// Start: SDA falls under a high SCL
			if (scl === 1'b1 && sclLast === 1'b1 && sdaLast === 1'b1 && sda === 1'b0)
			begin
				listening = 1'b1;
				frame     = 2'd0;
				bitCnt    = 4'd0;
				sdaLow    = 1'b0;
			end
			// Stop: SDA rises under a high SCL
			else if (scl === 1'b1 && sclLast === 1'b1 && sdaLast === 1'b0 && sda === 1'b1)
			begin
				listening = 1'b0;
				sdaLow    = 1'b0;
			end
			// Rising SCL samples the address bits and counts every bit
			else if (scl === 1'b1 && sclLast !== 1'b1 && listening)
			begin
				if (frame == 2'd0 && bitCnt < 4'd8)
					shIn = {shIn[6:0], sda};
				bitCnt = bitCnt + 4'd1;
			end
			// Falling SCL is where this model moves SDA
			else if (scl === 1'b0 && sclLast === 1'b1 && listening)
			begin
				if (frame == 2'd0 && bitCnt == 4'd8)
				begin
					// Ack only a read of our own address
					if (shIn == {adrs, 1'b1})
						sdaLow = 1'b1;
					else
						listening = 1'b0;
				end
				else if (bitCnt == 4'd9)
				begin
					// Ack slot over, next byte or done after the master NACK
					frame  = frame + 2'd1;
					bitCnt = 4'd0;
					sdaLow = (frame != 2'd3) && !txBit(frame, 4'd0);
					if (frame == 2'd3)
						listening = 1'b0;
				end
				else if (frame != 2'd0)
					sdaLow = (bitCnt < 4'd8) && !txBit(frame, bitCnt);
			end
			sclLast = scl;
			sdaLast = sda;
		end
	end

endmodule

`default_nettype wire
